// File: sources.f
eeprom_apb_pkg.sv
eeprom_ser_pkg.sv
eeprom_apb_regs.sv
eeprom_seq.sv
eeprom_bit_engine.sv
eeprom_ctrl_top.sv
tb_eeprom_chk.sv
tb_eeprom_model.sv
tb_eeprom_mon.sv
tb_eeprom.sv

// File: run.sh
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_eeprom \
    -f sources.f \
    -o tb_eeprom_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_eeprom_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0

// File: tb_eeprom.sv
`timescale 1ns/1ns
module tb_eeprom;

    localparam int CLK_DIV = 4;
    localparam int N_OPS   = 40; // upper bound on operations in all tests
    localparam int LIMIT_NS = N_OPS * 50 * 2 * CLK_DIV * 10 + 20000;

    logic                     CLK;
    logic                     RESET;
    eeprom_apb_pkg::apb_req_t apb_req;
    eeprom_apb_pkg::apb_rsp_t apb_rsp;
    logic                     scl;
    logic                     sda_oe;
    logic                     sda_in;
    logic                     model_pull;
    logic                     ack_en;
    logic [31:0]              lfsr;
    int                       errors;
    int                       checks;
    int                       base;
    int                       n_tests;

    assign sda_in = ~(sda_oe | model_pull); // open drain with pull-up

    eeprom_ctrl_top #(.CLK_DIV(CLK_DIV)) i_eeprom_ctrl_top
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in)
    );

    tb_eeprom_model i_model (.scl(scl), .sda(sda_in), .ack_en(ack_en), .pull(model_pull));

    tb_eeprom_mon i_mon (.CLK(CLK), .RESET(RESET), .apb_req(apb_req), .apb_rsp(apb_rsp));

    bind eeprom_ctrl_top tb_eeprom_chk i_eeprom_chk
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .busy    (op_busy),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial
    begin
        #(LIMIT_NS);
        $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic fail(input string msg);
        errors = errors + 1;
        $display("** Error @ %0t: %0s", $time, msg);
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        @(negedge CLK);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge CLK);
        apb_req.penable = 1'b1;
        #1;
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        if (apb_rsp.pready !== 1'b1)
            fail($sformatf("pready low in the access phase to %02h", addr));
        @(negedge CLK);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        if (err)
            fail($sformatf("unexpected pslverr on write to %02h", addr));
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'd0, data, err);
        if (err)
            fail($sformatf("unexpected pslverr on read of %02h", addr));
    endtask

    task automatic expect_refused(input logic wr, input logic [7:0] addr);
        logic [31:0] rd;
        logic        err;
        apb_xfer(wr, addr, 32'h2, rd, err);
        checks = checks + 1;
        if (!err)
            fail($sformatf("access to %02h was not refused", addr));
    endtask

    task automatic start_op(input logic is_read, input logic [10:0] a, input logic [7:0] d);
        apb_write(eeprom_apb_pkg::REG_ADDR, {21'd0, a});
        apb_write(eeprom_apb_pkg::REG_WDATA, {24'd0, d});
        apb_write(eeprom_apb_pkg::REG_CTRL, is_read ? 32'h2 : 32'h1);
    endtask

    // poll status until done and then check the flags
    task automatic finish_op(input logic exp_nack);
        logic [31:0] st;
        int          polls;
        polls = 0;
        do
        begin
            apb_read(eeprom_apb_pkg::REG_STATUS, st);
            polls = polls + 1;
        end
        while (!st[1] && polls < 2000);
        checks = checks + 1;
        if (!st[1])
        begin
            errors = errors + 1;
            $display("Operation never reported done at %0t", $time);
        end
        else if (st[2:0] != {exp_nack, 2'b10})
            fail($sformatf("status %03b, expected nack %b", st[2:0], exp_nack));
    endtask

    task automatic do_op(input logic is_read, input logic [10:0] a, input logic [7:0] d,
                         input logic exp_nack);
        logic [31:0] rd;
        start_op(is_read, a, d);
        finish_op(exp_nack);
        if (is_read && !exp_nack)
            apb_read(eeprom_apb_pkg::REG_RDATA, rd); // compared by the monitor
    endtask

    task automatic end_test(input string name);
        int e;
        e = errors + i_mon.errors - base;
        n_tests = n_tests + 1;
        $display("test %0s: %0s (%0d errors)", name, (e == 0) ? "ok" : "FAILED", e);
        base = errors + i_mon.errors;
    endtask

    initial
    begin
        logic [10:0] addrs [8];
        logic [31:0] r;
        logic [31:0] v;
        logic [10:0] a;
        apb_req = '0;
        RESET   = 1'b1;
        ack_en  = 1'b1;
        lfsr    = 32'h27b479ab;
        errors  = 0;
        checks  = 0;
        base    = 0;
        n_tests = 0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        // reset state
        checks = checks + 3;
        if (scl !== 1'b1 || sda_oe !== 1'b0)
            fail("bus not idle after reset");
        apb_read(eeprom_apb_pkg::REG_STATUS, r);
        if (r !== 32'd0)
            fail($sformatf("STATUS after reset is %08h", r));
        apb_read(eeprom_apb_pkg::REG_RDATA, r);
        if (r !== 32'd0)
            fail($sformatf("RDATA after reset is %08h", r));
        end_test("reset");

        // writes and overwrites followed by reads in a random rotation
        for (int i = 0; i < 8; i++)
        begin
            rand_bits(11, v);
            addrs[i] = v[10:0];
            rand_bits(8, r);
            do_op(1'b0, addrs[i], r[7:0], 1'b0);
        end
        for (int i = 0; i < 4; i++)
        begin
            rand_bits(8, r);
            do_op(1'b0, addrs[2 * i], r[7:0], 1'b0);
        end
        rand_bits(3, v);
        for (int k = 0; k < 8; k++)
            do_op(1'b1, addrs[(v + k) % 8], 8'd0, 1'b0);
        end_test("write_read");

        // one read per value of address bits 10..8
        for (int h = 0; h < 8; h++)
        begin
            rand_bits(8, v);
            do_op(1'b1, {3'(h), v[7:0]}, 8'd0, 1'b0);
        end
        end_test("unwritten");

        // nothing may change while the model stays silent
        @(negedge CLK);
        ack_en = 1'b0;
        rand_bits(8, r);
        do_op(1'b0, addrs[1], r[7:0], 1'b1);
        do_op(1'b1, addrs[1], 8'd0, 1'b1);
        @(negedge CLK);
        ack_en = 1'b1;
        do_op(1'b1, addrs[1], 8'd0, 1'b0);
        end_test("missing_ack");

        // refused accesses during a running write
        rand_bits(11, v);
        a = v[10:0];
        rand_bits(8, r);
        start_op(1'b0, a, r[7:0]);
        expect_refused(1'b1, eeprom_apb_pkg::REG_CTRL);
        expect_refused(1'b0, 8'h14);
        finish_op(1'b0);
        do_op(1'b1, a, 8'd0, 1'b0);
        end_test("refused");

        $display("summary: %0d tests, %0d checks, %0d errors", n_tests,
                 checks + i_mon.checks, errors + i_mon.errors);
        if (errors + i_mon.errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: tb_eeprom_mon.sv
`timescale 1ns/1ns
module tb_eeprom_mon
(
    input logic                     CLK,
    input logic                     RESET,
    input eeprom_apb_pkg::apb_req_t apb_req,
    input eeprom_apb_pkg::apb_rsp_t apb_rsp
);

    logic [7:0]  shadow [2048];
    logic        written [2048];
    logic [10:0] addr_reg;
    logic [7:0]  wdata_reg;
    logic        pend = 1'b0;      // operation started, done not yet seen
    logic        pend_read;
    logic [10:0] pend_addr;
    logic [7:0]  pend_data;
    logic        last_ok = 1'b0;   // last finished op was a good read
    logic [10:0] last_addr;
    int          errors = 0;
    int          checks = 0;

    // initial eeprom content, or the last byte written there
    function automatic logic [7:0] expected_byte(input logic [10:0] a);
        if (written[a])
            return shadow[a];
        return a[7:0] ^ {1'b0, a[10:8], 4'b0000};
    endfunction

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 2048; i++)
                written[i] = 1'b0;
            pend    = 1'b0;
            last_ok = 1'b0;
        end
        else if (apb_req.psel && apb_req.penable && !apb_rsp.pslverr)
        begin
            if (apb_req.pwrite)
            begin
                if (apb_req.paddr == eeprom_apb_pkg::REG_ADDR)
                    addr_reg = apb_req.pwdata[10:0];
                if (apb_req.paddr == eeprom_apb_pkg::REG_WDATA)
                    wdata_reg = apb_req.pwdata[7:0];
                if (apb_req.paddr == eeprom_apb_pkg::REG_CTRL && apb_req.pwdata[1:0] != 2'b00)
                begin
                    pend      = 1'b1;
                    pend_read = ~apb_req.pwdata[0];
                    pend_addr = addr_reg;
                    pend_data = wdata_reg;
                    last_ok   = 1'b0;
                end
            end
            else if (apb_req.paddr == eeprom_apb_pkg::REG_STATUS)
            begin
                if (pend && apb_rsp.prdata[eeprom_apb_pkg::STAT_DONE])
                begin
                    pend = 1'b0;
                    if (!apb_rsp.prdata[eeprom_apb_pkg::STAT_NACK])
                    begin
                        if (pend_read)
                        begin
                            last_ok   = 1'b1;
                            last_addr = pend_addr;
                        end
                        else
                        begin
                            shadow[pend_addr]  = pend_data;
                            written[pend_addr] = 1'b1;
                        end
                    end
                end
            end
            else if (apb_req.paddr == eeprom_apb_pkg::REG_RDATA && last_ok)
            begin
                checks = checks + 1;
                if (apb_rsp.prdata[7:0] !== expected_byte(last_addr))
                begin
                    errors = errors + 1;
                    $display("** Error @ %0t: RDATA for address %03h is %02h, expected %02h",
                             $time, last_addr, apb_rsp.prdata[7:0], expected_byte(last_addr));
                end
            end
        end
    end

endmodule

// File: tb_eeprom_model.sv
`timescale 1ns/1ns
module tb_eeprom_model
(
    input  logic scl,
    input  logic sda,
    input  logic ack_en, // 0 leaves every byte unacknowledged
    output logic pull    // 1 pulls sda low
);

    typedef enum logic [2:0] {P_IDLE, P_CTRL, P_ADDR, P_DATA, P_TX} phase_t;

    logic [7:0]  mem [2048];
    logic [7:0]  shreg;
    logic [10:0] ptr;
    int          cnt;
    phase_t      phase = P_IDLE;
    phase_t      next_phase = P_IDLE;
    logic        scl_d = 1'b1;
    logic        sda_d = 1'b1;
    logic        pull_q = 1'b0;

    assign pull = pull_q;

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'(a) ^ {1'b0, 3'(a >> 8), 4'b0000};
    end

    always @(scl or sda)
    begin
        if (scl && scl_d && sda_d && !sda)
        begin
            phase  = P_CTRL; // start or repeated start
            cnt    = 0;
            pull_q = 1'b0;
        end
        else if (scl && scl_d && !sda_d && sda)
        begin
            phase  = P_IDLE; // stop
            pull_q = 1'b0;
        end
        else if (scl && !scl_d && phase != P_IDLE)
        begin
            if (cnt < 8 && phase != P_TX)
                shreg = {shreg[6:0], sda};
            cnt = cnt + 1;
        end
        else if (!scl && scl_d && phase != P_IDLE)
        begin
            if (cnt == 8)
            begin
                pull_q     = 1'b0;
                next_phase = P_IDLE;
                case (phase)
                    P_CTRL:
                        if (shreg[7:4] == eeprom_ser_pkg::DEVICE_CODE && ack_en)
                        begin
                            pull_q      = 1'b1;
                            ptr[10:8]   = shreg[3:1];
                            next_phase  = shreg[0] ? P_TX : P_ADDR;
                        end
                    P_ADDR:
                        if (ack_en)
                        begin
                            ptr[7:0]   = shreg;
                            pull_q     = 1'b1;
                            next_phase = P_DATA;
                        end
                    P_DATA:
                        if (ack_en)
                        begin
                            mem[ptr] = shreg; // single byte, no page write
                            pull_q   = 1'b1;
                        end
                    default: ; // master answers the read byte
                endcase
            end
            else if (cnt == 9)
            begin
                cnt    = 0;
                pull_q = 1'b0;
                phase  = next_phase;
                if (phase == P_TX)
                begin
                    shreg  = mem[ptr];
                    pull_q = ~shreg[7];
                end
            end
            else if (phase == P_TX && cnt >= 1 && cnt <= 7)
                pull_q = ~shreg[7 - cnt];
        end
        scl_d = scl;
        sda_d = sda;
    end

endmodule

// File: tb_eeprom_chk.sv
`timescale 1ns/1ns
module tb_eeprom_chk
(
    input logic                     CLK,
    input logic                     RESET,
    input logic                     busy,
    input logic                     scl,
    input logic                     sda_oe,
    input eeprom_apb_pkg::apb_req_t apb_req,
    input eeprom_apb_pkg::apb_rsp_t apb_rsp
);

    // bus released while no operation runs
    idle_sda_released: assert property (@(posedge CLK) disable iff (RESET) !busy |-> !sda_oe)
        else $error("sda pulled low while the controller is idle");

    idle_scl_high: assert property (@(posedge CLK) disable iff (RESET) !busy |-> scl)
        else $error("scl low while the controller is idle");

    slverr_in_access: assert property (@(posedge CLK) disable iff (RESET)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr outside an APB access phase");

endmodule

// File: eeprom_ctrl_top.sv
`timescale 1ns/1ns
module eeprom_ctrl_top
#(
    parameter int CLK_DIV = 4 // clk cycles per scl half period
)
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  eeprom_apb_pkg::apb_req_t apb_req,
    output eeprom_apb_pkg::apb_rsp_t apb_rsp,
    output logic                     scl,
    output logic                     sda_oe, // 1 pulls sda low
    input  logic                     sda_in
);

    logic                       op_valid;
    eeprom_ser_pkg::eeprom_op_t op;
    logic                       op_busy;
    logic                       op_done;
    logic [7:0]                 rd_byte;
    logic                       nack;
    logic                       cmd_valid;
    eeprom_ser_pkg::ser_cmd_t   cmd;
    logic                       cmd_ready;
    logic                       rsp_valid;
    eeprom_ser_pkg::ser_rsp_t   rsp;

    eeprom_apb_regs i_eeprom_apb_regs
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .op_valid (op_valid),
        .op       (op),
        .op_busy  (op_busy),
        .op_done  (op_done),
        .rd_byte  (rd_byte),
        .nack     (nack)
    );

    eeprom_seq i_eeprom_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .op_valid  (op_valid),
        .op        (op),
        .op_busy   (op_busy),
        .op_done   (op_done),
        .rd_byte   (rd_byte),
        .nack      (nack),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    eeprom_bit_engine #(.CLK_DIV(CLK_DIV)) i_eeprom_bit_engine
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

// File: eeprom_bit_engine.sv
`timescale 1ns/1ns
module eeprom_bit_engine
#(
    parameter int CLK_DIV = 4
)
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     cmd_valid,
    input  eeprom_ser_pkg::ser_cmd_t cmd,
    output logic                     cmd_ready,
    output logic                     rsp_valid,
    output eeprom_ser_pkg::ser_rsp_t rsp,
    output logic                     scl,
    output logic                     sda_oe,
    input  logic                     sda_in
);

    localparam int            CW   = $clog2(CLK_DIV);
    localparam logic [CW-1:0] LAST = CW'(CLK_DIV - 1);
    localparam logic [CW-1:0] MID  = CW'(CLK_DIV / 2);

    typedef enum logic [1:0] {
        E_IDLE,
        E_START,
        E_STOP,
        E_BYTE
    } eng_state_t;

    eng_state_t    state;
    logic [CW-1:0] cnt;     // cycles within a half period
    logic          half;    // 0 = scl low half, 1 = scl high half
    logic [3:0]    bit_cnt; // 0..7 data, 8 ack
    logic [7:0]    shift;
    logic [7:0]    rx;
    logic          ack_in;
    logic          is_read;
    logic          ack_out;

    logic tick;
    logic set_pt;
    logic smp_pt;
    logic last_bit;
    logic low_oe;

    assign tick      = (cnt == LAST);
    assign set_pt    = ~half & (cnt == '0); // sda moves one cycle after scl falls
    assign smp_pt    = half & (cnt == MID);
    assign last_bit  = (state != E_BYTE) | (bit_cnt == 4'd8);
    assign cmd_ready = (state == E_IDLE);
    assign rsp       = '{data: rx, ack_in: ack_in};

    // sda drive for the low half of the current bit
    always_comb
    begin
        case (state)
            E_STOP: low_oe = 1'b1; // hold low so the stop edge is a rise
            E_BYTE:
                if (bit_cnt == 4'd8)
                    low_oe = is_read & ~ack_out;
                else
                    low_oe = ~is_read & ~shift[7];
            default: low_oe = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= E_IDLE;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
            rsp_valid <= 1'b0;
            cnt       <= '0;
            half      <= 1'b0;
            bit_cnt   <= 4'd0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            if (state == E_IDLE)
            begin
                if (cmd_valid)
                begin
                    cnt     <= '0;
                    half    <= 1'b0;
                    bit_cnt <= 4'd0;
                    scl     <= 1'b0; // every step opens with a low half
                    case (cmd.op)
                        eeprom_ser_pkg::STEP_START: state <= E_START;
                        eeprom_ser_pkg::STEP_STOP:  state <= E_STOP;
                        default:                    state <= E_BYTE;
                    endcase
                end
            end
            else
            begin
                cnt <= tick ? '0 : cnt + 1'b1;
                if (set_pt)
                    sda_oe <= low_oe;
                if (smp_pt && state != E_BYTE)
                    sda_oe <= (state == E_START); // start pulls sda, stop releases it
                if (tick)
                begin
                    if (!half)
                    begin
                        half <= 1'b1;
                        scl  <= 1'b1;
                    end
                    else if (last_bit)
                    begin
                        state     <= E_IDLE; // scl left high
                        rsp_valid <= 1'b1;
                    end
                    else
                    begin
                        half    <= 1'b0;
                        scl     <= 1'b0;
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end
        end
    end

    // data path
    always_ff @(posedge CLK)
    begin
        if (state == E_IDLE && cmd_valid)
        begin
            shift   <= cmd.data;
            is_read <= (cmd.op == eeprom_ser_pkg::STEP_READ);
            ack_out <= cmd.ack_out;
        end
        else if (state == E_BYTE)
        begin
            if (set_pt && bit_cnt != 4'd8)
                shift <= shift << 1; // msb first
            if (smp_pt)
            begin
                if (bit_cnt == 4'd8)
                    ack_in <= sda_in;
                else
                    rx <= {rx[6:0], sda_in};
            end
        end
    end

endmodule

// File: eeprom_seq.sv
`timescale 1ns/1ns
module eeprom_seq
(
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       op_valid,
    input  eeprom_ser_pkg::eeprom_op_t op,
    output logic                       op_busy,
    output logic                       op_done,
    output logic [7:0]                 rd_byte,
    output logic                       nack,
    output logic                       cmd_valid,
    output eeprom_ser_pkg::ser_cmd_t   cmd,
    input  logic                       cmd_ready,
    input  logic                       rsp_valid,
    input  eeprom_ser_pkg::ser_rsp_t   rsp
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_DONE
    } seq_state_t;

    seq_state_t                 state;
    seq_state_t                 next_byte;
    logic                       issued; // step handed to engine, waiting for rsp
    eeprom_ser_pkg::eeprom_op_t op_q;
    logic [7:0]                 rd_q;
    logic                       nack_q;

    assign op_busy   = (state != S_IDLE);
    assign op_done   = (state == S_DONE);
    assign rd_byte   = rd_q;
    assign nack      = nack_q;
    assign cmd_valid = op_busy & ~op_done & ~issued;

    always_comb
    begin
        cmd.op      = eeprom_ser_pkg::STEP_WRITE;
        cmd.data    = 8'd0;
        cmd.ack_out = 1'b0;
        case (state)
            S_START, S_RESTART: cmd.op = eeprom_ser_pkg::STEP_START;
            S_CTRL_W: cmd.data = {eeprom_ser_pkg::DEVICE_CODE, op_q.addr[10:8], 1'b0};
            S_ADDR:   cmd.data = op_q.addr[7:0];
            S_DATA_W: cmd.data = op_q.data;
            S_CTRL_R: cmd.data = {eeprom_ser_pkg::DEVICE_CODE, op_q.addr[10:8], 1'b1};
            S_DATA_R:
            begin
                cmd.op      = eeprom_ser_pkg::STEP_READ;
                cmd.ack_out = 1'b1; // single byte, answer with nack
            end
            S_STOP:   cmd.op = eeprom_ser_pkg::STEP_STOP;
            default:  ;
        endcase
    end

    // successor of each byte-out step when acknowledged
    always_comb
    begin
        case (state)
            S_CTRL_W: next_byte = S_ADDR;
            S_ADDR:   next_byte = op_q.is_read ? S_RESTART : S_DATA_W;
            S_CTRL_R: next_byte = S_DATA_R;
            default:  next_byte = S_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && op_valid)
            op_q <= op;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            issued <= 1'b0;
            nack_q <= 1'b0;
            rd_q   <= 8'd0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                issued <= 1'b1;
            if (rsp_valid)
                issued <= 1'b0;
            case (state)
                S_IDLE:
                    if (op_valid)
                    begin
                        nack_q <= 1'b0;
                        state  <= S_START;
                    end
                S_START:   if (rsp_valid) state <= S_CTRL_W;
                S_RESTART: if (rsp_valid) state <= S_CTRL_R;
                S_CTRL_W, S_ADDR, S_DATA_W, S_CTRL_R:
                    if (rsp_valid)
                    begin
                        if (rsp.ack_in)
                        begin
                            nack_q <= 1'b1; // no ack, abort with stop
                            state  <= S_STOP;
                        end
                        else
                            state <= next_byte;
                    end
                S_DATA_R:
                    if (rsp_valid)
                    begin
                        rd_q  <= rsp.data;
                        state <= S_STOP;
                    end
                S_STOP:    if (rsp_valid) state <= S_DONE;
                default:   state <= S_IDLE; // S_DONE lasts one cycle
            endcase
        end
    end

endmodule

// File: eeprom_apb_regs.sv
`timescale 1ns/1ns
module eeprom_apb_regs
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  eeprom_apb_pkg::apb_req_t  apb_req,
    output eeprom_apb_pkg::apb_rsp_t  apb_rsp,
    output logic                      op_valid,
    output eeprom_ser_pkg::eeprom_op_t op,
    input  logic                      op_busy,
    input  logic                      op_done,
    input  logic [7:0]                rd_byte,
    input  logic                      nack
);

    logic [10:0] addr_q;
    logic [7:0]  wdata_q;
    logic [7:0]  rdata_q;
    logic        done_q;
    logic        nack_q;

    logic access;
    logic wr;
    logic mapped;
    logic ctrl_wr;

    assign access  = apb_req.psel & apb_req.penable; // access phase only
    assign wr      = access & apb_req.pwrite;
    assign mapped  = apb_req.paddr inside {eeprom_apb_pkg::REG_ADDR, eeprom_apb_pkg::REG_WDATA,
                                           eeprom_apb_pkg::REG_CTRL, eeprom_apb_pkg::REG_STATUS,
                                           eeprom_apb_pkg::REG_RDATA};
    assign ctrl_wr = wr & (apb_req.paddr == eeprom_apb_pkg::REG_CTRL);

    // start only when idle and a start bit is set
    assign op_valid = ctrl_wr & ~op_busy & (apb_req.pwdata[1:0] != 2'b00);

    always_comb
    begin
        op.is_read = ~apb_req.pwdata[0]; // write wins if both bits set
        op.addr    = addr_q;
        op.data    = wdata_q;
    end

    always_comb
    begin
        apb_rsp         = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & (~mapped | (ctrl_wr & op_busy));
        case (apb_req.paddr)
            eeprom_apb_pkg::REG_ADDR:   apb_rsp.prdata = {21'd0, addr_q};
            eeprom_apb_pkg::REG_WDATA:  apb_rsp.prdata = {24'd0, wdata_q};
            eeprom_apb_pkg::REG_STATUS:
            begin
                apb_rsp.prdata[eeprom_apb_pkg::STAT_BUSY] = op_busy;
                apb_rsp.prdata[eeprom_apb_pkg::STAT_DONE] = done_q;
                apb_rsp.prdata[eeprom_apb_pkg::STAT_NACK] = nack_q;
            end
            eeprom_apb_pkg::REG_RDATA:  apb_rsp.prdata = {24'd0, rdata_q};
            default:                    apb_rsp.prdata = '0; // ctrl is write-only
        endcase
    end

    // address and data registers, writable any time
    always_ff @(posedge CLK)
    begin
        if (wr && apb_req.paddr == eeprom_apb_pkg::REG_ADDR)
            addr_q <= apb_req.pwdata[10:0];
        if (wr && apb_req.paddr == eeprom_apb_pkg::REG_WDATA)
            wdata_q <= apb_req.pwdata[7:0];
    end

    // sticky flags and read data
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            done_q  <= 1'b0;
            nack_q  <= 1'b0;
            rdata_q <= 8'd0;
        end
        else if (op_valid)
        begin
            done_q <= 1'b0;
            nack_q <= 1'b0;
        end
        else if (op_done)
        begin
            done_q  <= 1'b1;
            nack_q  <= nack;
            rdata_q <= rd_byte;
        end
    end

endmodule

// File: eeprom_ser_pkg.sv
package eeprom_ser_pkg;

    // one bus step for the bit engine
    typedef enum logic [1:0] {
        STEP_START = 2'd0, // start or repeated start
        STEP_STOP  = 2'd1,
        STEP_WRITE = 2'd2, // byte out, ack sampled
        STEP_READ  = 2'd3  // byte in, ack_out sent
    } step_op_t;

    typedef struct packed {
        step_op_t   op;
        logic [7:0] data;
        logic       ack_out; // level sent after a read byte, 1 = nack
    } ser_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       ack_in; // 0 = slave acknowledged
    } ser_rsp_t;

    // operation handed from registers to sequencer
    typedef struct packed {
        logic        is_read;
        logic [10:0] addr;
        logic [7:0]  data;
    } eeprom_op_t;

    // fixed upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage

// File: eeprom_apb_pkg.sv
package eeprom_apb_pkg;

    // APB request as seen by the slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map, byte offsets
    localparam logic [7:0] REG_ADDR   = 8'h00; // 11-bit eeprom address
    localparam logic [7:0] REG_WDATA  = 8'h04; // byte to write
    localparam logic [7:0] REG_CTRL   = 8'h08; // bit0 write, bit1 read
    localparam logic [7:0] REG_STATUS = 8'h0C; // bit0 busy, bit1 done, bit2 nack
    localparam logic [7:0] REG_RDATA  = 8'h10; // last byte read

    // status bit positions
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;
    localparam int STAT_NACK = 2;

endpackage
